/* all.f */
hw/serial_frame_pkg.sv
hw/serial_regs_pkg.sv
hw/serial_word_if.sv
hw/baud_tick_gen.sv
hw/async_tx.sv
hw/async_rx.sv
hw/apb_serial_regs.sv
hw/serial_apb_top.sv
verif/tb_serial_apb.sv

/* Makefile */
# Verilator flow for the APB serial controller testbench
VERILATOR ?= verilator
TOP ?= tb_serial_apb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= ** PASS **
SIM ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation binary
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* verif/serial_patterns.txt */
// columns: op, address or word, expected value
// op 1 write (exp pslverr), 2 read (exp prdata), 3 loopback, 4 bad parity, 5 bad stop (exp STATUS), 0 end
2 8 00000000    // clean status after reset
1 0 00000000    // random word onto serial_out
2 8 00000001    // transmitter still busy
1 0 00000001    // refused while busy
3 a5 00000002   // loopback, word waits in RXDATA
2 4 000000a5
2 8 00000000    // read cleared rx_valid
3 3c 00000002
2 4 0000003c
4 5a 00000006   // parity error
5 c3 0000001e   // frame error plus overrun
2 4 000000c3    // newest word kept
2 8 00000000    // all flags cleared
1 c 00000001    // unmapped write
2 c 00000000    // unmapped read
1 0 00000000
0 0 00000000

/* verif/tb_serial_apb.sv */
// testbench that steps the APB serial controller through the ops listed in its pattern file
`timescale 1ns/1ps
`default_nettype none

module tb_serial_apb;

	localparam int bit_cycles = serial_frame_pkg::oversample * serial_frame_pkg::clks_per_tick;
	// start, data, parity and stop
	localparam int frame_cycles = (serial_frame_pkg::data_bits + 3) * bit_cycles;
	localparam int max_ops = 32;
	localparam logic [31:0] busy_mask = 32'h1 << serial_regs_pkg::st_tx_busy;
	localparam logic [31:0] rx_mask = 32'h1 << serial_regs_pkg::st_rx_valid;

	logic serial_clk;
	logic in_rst;
	logic [serial_regs_pkg::addr_width-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pslverr;
	logic serial_in;
	logic serial_out;
	// line mux select and bit-banger level
	logic loop_sel;
	logic bang_line;

	// three words per op
	logic [31:0] pat_mem [0:3*max_ops-1];
	int n_ops;
	int check_fails;
	integer seed;
	// words still owed on serial_out
	serial_frame_pkg::word_t tx_expect [$];
	logic mon_busy;

	assign serial_in = loop_sel ? serial_out : bang_line;

	serial_apb_top DUT (
		.serial_clk (serial_clk),
		.in_rst     (in_rst),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pslverr    (pslverr),
		.serial_in  (serial_in),
		.serial_out (serial_out)
	);

	initial serial_clk = 1'b0;
	always #20 serial_clk = ~serial_clk;

	// --------------------------------------------------
	// reporting
	// --------------------------------------------------
	task automatic stop_on_failure(input string why);
		check_fails++;
		$display("** FAIL **");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
			stop_on_failure("value mismatch");
		end
	endtask

	// --------------------------------------------------
	// bus and line drivers
	// --------------------------------------------------
	// setup, access, one idle cycle
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge serial_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge serial_clk);
		penable = 1'b1;
		// response already registered at end of setup
		rdata = prdata;
		err = pslverr;
		@(negedge serial_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
	endtask

	// poll STATUS until the set bits are up and the clear bits are down
	task automatic wait_status(input logic [31:0] set_mask, input logic [31:0] clr_mask,
		output logic [31:0] status);
		int polls;
		logic err;
		polls = 0;
		apb_access(1'b0, serial_regs_pkg::reg_status, '0, status, err);
		while (((status & set_mask) != set_mask) || ((status & clr_mask) != '0)) begin
			polls++;
			if (polls > frame_cycles) begin
				stop_on_failure("STATUS never reached the awaited flags");
			end
			apb_access(1'b0, serial_regs_pkg::reg_status, '0, status, err);
		end
	endtask

	// frame built from the line rules with optional faults
	task automatic send_frame(input serial_frame_pkg::word_t w, input logic bad_parity,
		input logic bad_stop);
		logic [10:0] bits;
		bits = {(bad_stop ? 1'b0 : 1'b1), (^w) ^ bad_parity, w, 1'b0};
		@(negedge serial_clk);
		for (int i = 0; i < 11; i++) begin
			bang_line = bits[i];
			repeat (bit_cycles) @(negedge serial_clk);
		end
		bang_line = 1'b1;
		repeat (bit_cycles) @(negedge serial_clk);
	endtask

	// --------------------------------------------------
	// serial_out monitor sampling at mid-bit
	// --------------------------------------------------
	initial begin
		serial_frame_pkg::word_t w;
		logic [10:0] bits;
		mon_busy = 1'b0;
		@(negedge in_rst);
		forever begin
			@(negedge serial_clk);
			if (serial_out === 1'b0) begin
				mon_busy = 1'b1;
				if (tx_expect.size() == 0) begin
					stop_on_failure("frame on serial_out with no word written");
				end
				w = tx_expect.pop_front();
				// stop, even parity, data LSB first, start
				bits = {1'b1, ^w, w, 1'b0};
				repeat (bit_cycles / 2) @(negedge serial_clk);
				for (int i = 0; i < 11; i++) begin
					check_value($sformatf("serial_out bit %0d", i), 32'(serial_out), 32'(bits[i]));
					if (i < 10) begin
						repeat (bit_cycles) @(negedge serial_clk);
					end
				end
				mon_busy = 1'b0;
			end
		end
	end

	// watchdog sized at fifteen frame times per op
	initial begin
		@(negedge in_rst);
		repeat (n_ops * 15 * frame_cycles) @(posedge serial_clk);
		$display("run took longer than 15 frame times for each of %0d ops", n_ops);
		stop_on_failure("watchdog timeout");
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		logic [31:0] op;
		logic [31:0] arg;
		logic [31:0] exp;
		logic [31:0] rdata;
		logic [31:0] status;
		logic err;
		serial_frame_pkg::word_t w;
		in_rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		loop_sel = 1'b0;
		bang_line = 1'b1;
		check_fails = 0;
		seed = 51;
		n_ops = 0;
		$readmemh("verif/serial_patterns.txt", pat_mem);
		// op 0 ends the list
		while (n_ops < max_ops && pat_mem[3*n_ops] != 0) begin
			n_ops++;
		end
		assert (n_ops > 0) else stop_on_failure("pattern file empty or missing");
		repeat (16) @(negedge serial_clk);
		in_rst = 1'b0;
		@(negedge serial_clk);
		check_value("serial_out", 32'(serial_out), 32'h1);
		check_value("prdata", prdata, 32'h0);
		check_value("pslverr", 32'(pslverr), 32'h0);

		for (int i = 0; i < n_ops; i++) begin
			op = pat_mem[3*i];
			arg = pat_mem[3*i+1];
			exp = pat_mem[3*i+2];
			case (op)
				1: begin
					w = serial_frame_pkg::word_t'($random(seed));
					apb_access(1'b1, arg[3:0], 32'(w), rdata, err);
					check_value("pslverr", 32'(err), exp);
					// an accepted TXDATA write owes one frame
					if (arg[3:0] == serial_regs_pkg::reg_txdata && exp == 0) begin
						tx_expect.push_back(w);
					end
				end
				2: begin
					apb_access(1'b0, arg[3:0], '0, rdata, err);
					check_value("prdata", rdata, exp);
					// only mapped registers answer without error
					check_value("pslverr", 32'(err),
						32'(arg[3:0] != 4'h0 && arg[3:0] != 4'h4 && arg[3:0] != 4'h8));
				end
				3: begin
					wait_status(32'h0, busy_mask, status);
					loop_sel = 1'b1;
					w = serial_frame_pkg::word_t'(arg);
					apb_access(1'b1, serial_regs_pkg::reg_txdata, 32'(w), rdata, err);
					check_value("pslverr", 32'(err), 32'h0);
					tx_expect.push_back(w);
					// rx_valid up and transmitter released
					wait_status(rx_mask, busy_mask, status);
					loop_sel = 1'b0;
					check_value("STATUS", status, exp);
				end
				4, 5: begin
					send_frame(serial_frame_pkg::word_t'(arg), op == 4, op == 5);
					wait_status(rx_mask, busy_mask, status);
					check_value("STATUS", status, exp);
				end
				default: stop_on_failure("unknown op in pattern file");
			endcase
		end

		// let the last frame finish
		wait_status(32'h0, busy_mask, status);
		repeat (bit_cycles) @(negedge serial_clk);
		assert (tx_expect.size() == 0 && !mon_busy)
			else stop_on_failure("a written word never appeared on serial_out");
		if (check_fails == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_on_failure("checks failed");
		end
	end

endmodule

`default_nettype wire

/* hw/serial_apb_top.sv */
// top level of the APB serial controller that joins tick source, engines and register block
`timescale 1ns/1ps
`default_nettype none

module serial_apb_top (
	input logic serial_clk,
	input logic in_rst,
	// APB slave
	input logic [serial_regs_pkg::addr_width-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [serial_regs_pkg::apb_data_width-1:0] pwdata,
	output logic [serial_regs_pkg::apb_data_width-1:0] prdata,
	output logic pslverr,
	// serial line
	input logic serial_in,
	output logic serial_out
);

	logic tick;

	tx_word_if tx_word ();
	rx_word_if rx_word ();

	// --------------------------------------------------
	// shared time base
	// --------------------------------------------------
	baud_tick_gen u_tick (
		.serial_clk (serial_clk),
		.in_rst     (in_rst),
		.tick       (tick)
	);

	// --------------------------------------------------
	// serial engines
	// --------------------------------------------------
	async_tx u_tx (
		.serial_clk (serial_clk),
		.in_rst     (in_rst),
		.tick       (tick),
		.word       (tx_word),
		.serial_out (serial_out)
	);

	async_rx u_rx (
		.serial_clk (serial_clk),
		.in_rst     (in_rst),
		.tick       (tick),
		.serial_in  (serial_in),
		.word       (rx_word)
	);

	// register block
	apb_serial_regs u_regs (
		.serial_clk (serial_clk),
		.in_rst     (in_rst),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pslverr    (pslverr),
		.tx         (tx_word),
		.rx         (rx_word)
	);

endmodule

`default_nettype wire

/* hw/apb_serial_regs.sv */
// APB slave with TXDATA, RXDATA and STATUS that feeds the transmitter and holds received words
`timescale 1ns/1ps
`default_nettype none

module apb_serial_regs (
	input logic serial_clk,
	input logic in_rst,
	input logic [serial_regs_pkg::addr_width-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [serial_regs_pkg::apb_data_width-1:0] pwdata,
	output logic [serial_regs_pkg::apb_data_width-1:0] prdata,
	output logic pslverr,
	tx_word_if.src tx,
	rx_word_if.dst rx
);

	logic setup;
	logic access;
	logic wr_tx;
	logic rd_rx;
	logic [serial_regs_pkg::apb_data_width-1:0] rdata_d;
	logic err_d;
	logic [serial_regs_pkg::apb_data_width-1:0] status;

	// held receive word and sticky flags
	serial_frame_pkg::word_t rx_data_q;
	logic rx_valid_q;
	logic parity_err_q;
	logic frame_err_q;
	logic overrun_q;

	assign setup = psel && !penable;
	assign access = psel && penable;
	// pslverr from setup also drops the write
	assign wr_tx = access && pwrite && (paddr == serial_regs_pkg::reg_txdata) && !pslverr;
	assign rd_rx = access && !pwrite && (paddr == serial_regs_pkg::reg_rxdata);

	assign rx.ready = 1'b1;

	// --------------------------------------------------
	// status and read decode
	// --------------------------------------------------
	always_comb begin
		status = '0;
		status[serial_regs_pkg::st_tx_busy] = tx.busy;
		status[serial_regs_pkg::st_rx_valid] = rx_valid_q;
		status[serial_regs_pkg::st_parity_err] = parity_err_q;
		status[serial_regs_pkg::st_frame_err] = frame_err_q;
		status[serial_regs_pkg::st_overrun] = overrun_q;
	end

	always_comb begin
		rdata_d = '0;
		err_d = 1'b0;
		case (serial_regs_pkg::reg_addr_t'(paddr))
			// write only, busy transmitter refuses
			serial_regs_pkg::reg_txdata: err_d = pwrite && tx.busy;
			serial_regs_pkg::reg_rxdata: begin
				err_d = pwrite;
				rdata_d = serial_regs_pkg::apb_data_width'(rx_data_q);
			end
			serial_regs_pkg::reg_status: begin
				err_d = pwrite;
				rdata_d = status;
			end
			// unmapped
			default: err_d = 1'b1;
		endcase
	end

	// response registered in setup, seen in access
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			prdata <= '0;
			pslverr <= 1'b0;
		end else if (setup) begin
			prdata <= pwrite ? '0 : rdata_d;
			pslverr <= err_d;
		end else if (!psel) begin
			prdata <= '0;
			pslverr <= 1'b0;
		end
	end

	// --------------------------------------------------
	// transmit side
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			tx.valid <= 1'b0;
		end else if (wr_tx) begin
			tx.valid <= 1'b1;
		end else if (tx.valid && tx.ready) begin
			tx.valid <= 1'b0;
		end
	end

	always_ff @(posedge serial_clk) begin
		if (wr_tx) begin
			tx.data <= pwdata[serial_frame_pkg::data_bits-1:0];
		end
	end

	// --------------------------------------------------
	// receive side
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			rx_data_q <= '0;
			rx_valid_q <= 1'b0;
			parity_err_q <= 1'b0;
			frame_err_q <= 1'b0;
			overrun_q <= 1'b0;
		end else begin
			if (rd_rx) begin
				rx_valid_q <= 1'b0;
				parity_err_q <= 1'b0;
				frame_err_q <= 1'b0;
				overrun_q <= 1'b0;
			end
			// new word wins over a clearing read
			if (rx.valid && rx.ready) begin
				rx_data_q <= rx.data;
				rx_valid_q <= 1'b1;
				if (rx_valid_q && !rd_rx) begin
					overrun_q <= 1'b1;
				end
				if (rx.parity_err) begin
					parity_err_q <= 1'b1;
				end
				if (rx.frame_err) begin
					frame_err_q <= 1'b1;
				end
			end
		end
	end

	// zero wait states so access follows exactly one setup
	a_apb_phase: assert property (@(posedge serial_clk) disable iff (in_rst)
		penable |-> psel && $past(psel && !penable));

endmodule

`default_nettype wire

/* hw/async_rx.sv */
// frame deserializer that samples the line at mid bit and reports the word with its errors
`timescale 1ns/1ps
`default_nettype none

module async_rx (
	input logic serial_clk,
	input logic in_rst,
	input logic tick,
	input logic serial_in,
	rx_word_if.src word
);

	// line synchronizer and edge history
	logic [1:0] sync_q;
	logic rx_s;
	logic rx_prev;

	serial_frame_pkg::rx_state_t state;
	logic [serial_frame_pkg::os_cnt_width-1:0] os_cnt;
	logic [serial_frame_pkg::bit_cnt_width-1:0] bit_cnt;
	serial_frame_pkg::word_t shift_q;
	// expected parity bit so far
	logic parity;
	logic parity_bad;
	logic frame_bad;
	logic sample;

	// --------------------------------------------------
	// input sync
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			sync_q <= {2{serial_frame_pkg::line_idle}};
			rx_prev <= serial_frame_pkg::line_idle;
		end else begin
			sync_q <= {sync_q[0], serial_in};
			rx_prev <= sync_q[1];
		end
	end

	assign rx_s = sync_q[1];

	// mid-bit sample point
	assign sample = tick &&
		(os_cnt == serial_frame_pkg::os_cnt_width'(serial_frame_pkg::oversample - 1));

	assign word.data = shift_q;
	assign word.parity_err = parity_bad;
	assign word.frame_err = frame_bad;

	// --------------------------------------------------
	// receive state machine
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= serial_frame_pkg::rx_idle;
			os_cnt <= '0;
			bit_cnt <= '0;
			parity <= ~serial_frame_pkg::even_parity;
			parity_bad <= 1'b0;
			frame_bad <= 1'b0;
			word.valid <= 1'b0;
		end else begin
			if (word.valid && word.ready) begin
				word.valid <= 1'b0;
			end
			if (sample) begin
				os_cnt <= '0;
			end else if (tick) begin
				os_cnt <= os_cnt + 1'b1;
			end

			unique case (state)
				serial_frame_pkg::rx_idle: begin
					os_cnt <= '0;
					bit_cnt <= '0;
					parity <= ~serial_frame_pkg::even_parity;
					// falling edge
					if (rx_prev == serial_frame_pkg::line_idle &&
						rx_s == serial_frame_pkg::start_level) begin
						state <= serial_frame_pkg::rx_start;
					end
				end
				serial_frame_pkg::rx_start: begin
					// glitch, line went back high
					if (rx_s != serial_frame_pkg::start_level) begin
						state <= serial_frame_pkg::rx_idle;
					end else if (tick && os_cnt ==
						serial_frame_pkg::os_cnt_width'(serial_frame_pkg::oversample / 2 - 1)) begin
						// middle of start bit reached
						os_cnt <= '0;
						state <= serial_frame_pkg::rx_data;
					end
				end
				serial_frame_pkg::rx_data: begin
					if (sample) begin
						parity <= parity ^ rx_s;
						if (bit_cnt == serial_frame_pkg::bit_cnt_width'(serial_frame_pkg::data_bits - 1)) begin
							bit_cnt <= '0;
							state <= serial_frame_pkg::rx_parity;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				serial_frame_pkg::rx_parity: begin
					if (sample) begin
						parity_bad <= (rx_s != parity);
						state <= serial_frame_pkg::rx_stop;
					end
				end
				serial_frame_pkg::rx_stop: begin
					// word goes out with both checks
					if (sample) begin
						frame_bad <= (rx_s != serial_frame_pkg::stop_level);
						word.valid <= 1'b1;
						state <= serial_frame_pkg::rx_idle;
					end
				end
				default: begin
					state <= serial_frame_pkg::rx_idle;
				end
			endcase
		end
	end

	// data bits enter at the top, LSB arrives first
	always_ff @(posedge serial_clk) begin
		if (state == serial_frame_pkg::rx_data && sample) begin
			shift_q <= {rx_s, shift_q[serial_frame_pkg::data_bits-1:1]};
		end
	end

	// register block takes each word at once
	a_valid_pulse: assert property (@(posedge serial_clk) disable iff (in_rst)
		word.valid |=> !word.valid);

endmodule

`default_nettype wire

/* hw/async_tx.sv */
// frame serializer that turns one accepted word into start, data, parity and stop bits
`timescale 1ns/1ps
`default_nettype none

module async_tx (
	input logic serial_clk,
	input logic in_rst,
	input logic tick,
	tx_word_if.dst word,
	output logic serial_out
);

	serial_frame_pkg::tx_state_t state;
	// word accepted and waiting for the next tick
	logic armed;
	logic [serial_frame_pkg::os_cnt_width-1:0] os_cnt;
	logic [serial_frame_pkg::bit_cnt_width-1:0] bit_cnt;
	serial_frame_pkg::word_t shift_q;
	// running parity over bits already sent
	logic parity;
	logic bit_end;

	// --------------------------------------------------
	// handshake
	// --------------------------------------------------
	assign word.ready = (state == serial_frame_pkg::tx_idle);
	// high from the transfer cycle until the stop bit ends
	assign word.busy = word.valid || armed || (state != serial_frame_pkg::tx_idle);

	// last tick of the current bit
	assign bit_end = tick &&
		(os_cnt == serial_frame_pkg::os_cnt_width'(serial_frame_pkg::oversample - 1));

	// --------------------------------------------------
	// frame state machine
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			state <= serial_frame_pkg::tx_idle;
			armed <= 1'b0;
			os_cnt <= '0;
			bit_cnt <= '0;
			parity <= ~serial_frame_pkg::even_parity;
		end else begin
			// tick sub-counter inside a bit
			if (bit_end) begin
				os_cnt <= '0;
			end else if (tick) begin
				os_cnt <= os_cnt + 1'b1;
			end

			unique case (state)
				serial_frame_pkg::tx_idle: begin
					os_cnt <= '0;
					bit_cnt <= '0;
					parity <= ~serial_frame_pkg::even_parity;
					if (word.valid && word.ready) begin
						armed <= 1'b1;
					end
					// start bit begins on a tick edge
					if (armed && tick) begin
						armed <= 1'b0;
						state <= serial_frame_pkg::tx_start;
					end
				end
				serial_frame_pkg::tx_start: begin
					if (bit_end) begin
						state <= serial_frame_pkg::tx_data;
					end
				end
				serial_frame_pkg::tx_data: begin
					if (bit_end) begin
						// fold the bit just sent into parity
						parity <= parity ^ shift_q[0];
						if (bit_cnt ==
							serial_frame_pkg::bit_cnt_width'(serial_frame_pkg::data_bits - 1)) begin
							bit_cnt <= '0;
							state <= serial_frame_pkg::tx_parity;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				serial_frame_pkg::tx_parity: begin
					if (bit_end) begin
						state <= serial_frame_pkg::tx_stop;
					end
				end
				serial_frame_pkg::tx_stop: begin
					if (bit_end) begin
						state <= serial_frame_pkg::tx_idle;
					end
				end
				default: begin
					state <= serial_frame_pkg::tx_idle;
				end
			endcase
		end
	end

	// data shifter sending the LSB first
	always_ff @(posedge serial_clk) begin
		if (word.valid && word.ready) begin
			shift_q <= word.data;
		end else if (state == serial_frame_pkg::tx_data && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	// --------------------------------------------------
	// line driver
	// --------------------------------------------------
	always_comb begin
		unique case (state)
			serial_frame_pkg::tx_start: serial_out = serial_frame_pkg::start_level;
			serial_frame_pkg::tx_data: serial_out = shift_q[0];
			serial_frame_pkg::tx_parity: serial_out = parity;
			serial_frame_pkg::tx_stop: serial_out = serial_frame_pkg::stop_level;
			default: serial_out = serial_frame_pkg::line_idle;
		endcase
	end

	// line rests high between frames
	a_idle_line: assert property (@(posedge serial_clk) disable iff (in_rst)
		(state == serial_frame_pkg::tx_idle) |-> (serial_out == serial_frame_pkg::line_idle));

	// bit boundaries follow the shared tick
	a_tick_step: assert property (@(posedge serial_clk) disable iff (in_rst)
		(state != $past(state)) |-> $past(tick));

endmodule

`default_nettype wire

/* hw/baud_tick_gen.sv */
// oversample tick source shared by transmitter and receiver as their one time base
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
	input logic serial_clk,
	input logic in_rst,
	output logic tick
);

	// down counter reloaded every period
	logic [serial_frame_pkg::tick_cnt_width-1:0] cnt;

	// --------------------------------------------------
	// free running divider
	// --------------------------------------------------
	always_ff @(posedge serial_clk or posedge in_rst) begin
		if (in_rst) begin
			cnt <= serial_frame_pkg::tick_cnt_width'(serial_frame_pkg::clks_per_tick - 1);
			tick <= 1'b0;
		end else begin
			// pulse on the wrap and reload
			if (cnt == '0) begin
				cnt <= serial_frame_pkg::tick_cnt_width'(serial_frame_pkg::clks_per_tick - 1);
				tick <= 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
				tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/serial_word_if.sv */
// word handoff bundles between the APB register block and the serial engines
`timescale 1ns/1ps
`default_nettype none

// register block to transmitter
interface tx_word_if;
	logic valid;
	logic ready;
	serial_frame_pkg::word_t data;
	// set from transfer until stop bit ends
	logic busy;

	modport src (output valid, output data, input ready, input busy);
	modport dst (input valid, input data, output ready, output busy);
endinterface

// receiver to register block
interface rx_word_if;
	// one cycle pulse per received frame
	logic valid;
	logic ready;
	serial_frame_pkg::word_t data;
	logic parity_err;
	logic frame_err;

	modport src (output valid, output data, output parity_err, output frame_err,
		input ready);
	modport dst (input valid, input data, input parity_err, input frame_err,
		output ready);
endinterface

`default_nettype wire

/* hw/serial_regs_pkg.sv */
// APB register map of the serial controller and the bit layout of its status register
`default_nettype none

package serial_regs_pkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------
	localparam int addr_width = 4;
	localparam int apb_data_width = 32;

	// --------------------------------------------------
	// register byte addresses
	// --------------------------------------------------
	typedef enum logic [addr_width-1:0] {
		// write starts a frame
		reg_txdata = 4'h0,
		// read returns held word and clears flags
		reg_rxdata = 4'h4,
		// read only
		reg_status = 4'h8
	} reg_addr_t;

	// --------------------------------------------------
	// status bit positions
	// --------------------------------------------------
	// transmitter holds or sends a word
	localparam int st_tx_busy = 0;
	// unread word waiting in RXDATA
	localparam int st_rx_valid = 1;
	// sticky until RXDATA read
	localparam int st_parity_err = 2;
	localparam int st_frame_err = 3;
	// word lost to a newer one
	localparam int st_overrun = 4;

endpackage

`default_nettype wire

/* hw/serial_frame_pkg.sv */
// frame format and bit timing shared by the serial engines and compiled ahead of them
`default_nettype none

package serial_frame_pkg;

	// --------------------------------------------------
	// word and frame shape
	// --------------------------------------------------
	localparam int data_bits = 8;
	typedef logic [data_bits-1:0] word_t;

	// ones over data plus parity stay even
	localparam logic even_parity = 1'b1;

	// line levels
	localparam logic line_idle = 1'b1;
	localparam logic start_level = 1'b0;
	localparam logic stop_level = 1'b1;

	// --------------------------------------------------
	// bit timing
	// --------------------------------------------------
	// ticks per bit
	localparam int oversample = 8;
	// serial_clk cycles per tick, so one bit is 32 cycles
	localparam int clks_per_tick = 4;

	// counter widths
	localparam int tick_cnt_width = $clog2(clks_per_tick + 1);
	localparam int os_cnt_width = $clog2(oversample);
	localparam int bit_cnt_width = $clog2(data_bits);

	// engine states
	typedef enum logic [2:0] {tx_idle, tx_start, tx_data, tx_parity, tx_stop} tx_state_t;
	typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_parity, rx_stop} rx_state_t;

endpackage

`default_nettype wire
